// ==== Makefile ====
# Verilator build and run of the divide unit testbench

VERILATOR ?= verilator
TOP ?= fdivTb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
SIM_ARGS ?= +verilator+error+limit+100
FAIL_MSG ?= ** FAIL **

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q -F '$(FAIL_MSG)' $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/clockGen.sv ====
// testbench clock and reset source
// 8 ns clock, active-low reset held for the first 16 cycles

module clockGen #(
	parameter int PERIOD = 8,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rstN
);

	timeunit 1ns;
	timeprecision 100ps;

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	// reset released on a rising edge
	initial begin
		rstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rstN <= 1'b1;
	end

endmodule

// ==== bench/fdivTb.sv ====
// testbench top for the divide unit
// host request-credit model and consumer output-credit model
// exact, truncation, special, range, credit and back-pressure tests

module fdivTb;

	timeunit 1ns;
	timeprecision 100ps;

	import fdivPkg::*;

	localparam int NUM_LANES = 2;
	localparam int OUT_CREDITS = 4;
	// cycles any single wait may take
	localparam int WAIT_LIMIT = 200;

	localparam flagsT NO_FLAGS = '0;
	localparam flagsT DBZ = flagsT'(1) << FLAG_DBZ;
	localparam flagsT INV = flagsT'(1) << FLAG_INV;
	localparam flagsT OVUF = flagsT'(1) << FLAG_OVUF;

	logic clk;
	logic rstN;
	logic reqValid;
	float32T reqA;
	float32T reqB;
	tagT reqTag;
	logic reqCredit;
	logic resCredit;
	logic resValid;
	float32T resValue;
	flagsT resFlags;
	tagT resTag;

	int seed = 32'hcbc8;
	string testName = "reset";
	// host and consumer bookkeeping
	int sent;
	int returned;
	int received;
	int outstanding;
	int errors;
	int tests;
	int errAtStart;
	int recvAtStart;
	int retAtStart;
	tagT nextTag;
	// expectation per tag, filled when the request goes out
	float32T expVal [16];
	flagsT expFlags [16];
	logic pending [16];

	clockGen uClk (
		.clk(clk),
		.rstN(rstN)
	);

	fdivTop #(
		.NUM_LANES(NUM_LANES),
		.OUT_CREDITS(OUT_CREDITS)
	) uut (
		.clk(clk),
		.rstN(rstN),
		.reqValid(reqValid),
		.reqA(reqA),
		.reqB(reqB),
		.reqTag(reqTag),
		.reqCredit(reqCredit),
		.resCredit(resCredit),
		.resValid(resValid),
		.resValue(resValue),
		.resFlags(resFlags),
		.resTag(resTag)
	);

	// =================================================
	// helpers
	// =================================================

	function automatic int hostCredits();
		return NUM_LANES + returned - sent;
	endfunction

	// exact integer to single precision, n from 1 to 2^24-1
	function automatic float32T intToFloat(input logic [31:0] n);
		int pos;
		logic [31:0] m;
		pos = 0;
		for (int i = 0; i < 24; i++) begin
			if (n[i]) pos = i;
		end
		m = n << (23 - pos);
		return {1'b0, 8'(127 + pos), m[22:0]};
	endfunction

	// one idle edge, request and credit lines low
	task automatic tick();
		@(posedge clk);
		reqValid <= 1'b0;
		resCredit <= 1'b0;
	endtask

	// request once the host holds a credit; withCredit also grants an output slot
	task automatic sendReq(input float32T a, input float32T b, input float32T ev,
		input flagsT ef, input logic withCredit);
		int waited;
		waited = 0;
		while (hostCredits() == 0 && waited < WAIT_LIMIT) begin
			tick();
			waited++;
		end
		if (hostCredits() == 0) begin
			$display("ERROR: %s: no request credit came back in time", testName);
			errors++;
		end else begin
			@(posedge clk);
			expVal[nextTag] = ev;
			expFlags[nextTag] = ef;
			pending[nextTag] = 1'b1;
			outstanding++;
			sent++;
			reqValid <= 1'b1;
			reqA <= a;
			reqB <= b;
			reqTag <= nextTag;
			resCredit <= withCredit;
			nextTag = nextTag + 4'd1;
		end
	endtask

	// p*q over q, both exact, quotient exactly p
	task automatic sendExact(input logic withCredit);
		logic [31:0] r;
		int p;
		int q;
		r = $random(seed);
		p = 1 + int'(r % 32'd4095);
		r = $random(seed);
		q = 1 + int'(r % 32'd4095);
		sendReq(intToFloat(p * q), intToFloat(q), intToFloat(p), NO_FLAGS, withCredit);
	endtask

	task automatic grantCredit();
		@(posedge clk);
		reqValid <= 1'b0;
		resCredit <= 1'b1;
		tick();
	endtask

	task automatic waitResults(input int target);
		int n;
		n = 0;
		while (received < target && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (received < target) begin
			$display("ERROR: %s: result never arrived after its credit", testName);
			errors++;
		end
	endtask

	task automatic startTest(input string name);
		testName = name;
		errAtStart = errors;
		recvAtStart = received;
		retAtStart = returned;
	endtask

	// drain, then check one request credit per result
	task automatic finishTest();
		int n;
		n = 0;
		while (outstanding != 0 && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (outstanding != 0) begin
			$display("ERROR: %s: %0d results still missing", testName, outstanding);
			errors++;
		end
		repeat (4) tick();
		assert (returned - retAtStart == received - recvAtStart) else begin
			$display("CHECK FAILED %s: request credits expected %0d actual %0d",
				testName, received - recvAtStart, returned - retAtStart);
			errors++;
		end
		tests++;
		$display("test %s finished with %0d errors", testName, errors - errAtStart);
	endtask

	// =================================================
	// result monitor, consumer takes every pulse
	// =================================================

	always @(posedge clk) begin
		if (reqCredit) returned++;
		if (resValid) begin
			received++;
			assert (pending[resTag]) else begin
				$display("ERROR: %s: result with tag %0d that was not outstanding",
					testName, resTag);
				errors++;
			end
			assert (resValue == expVal[resTag] && resFlags == expFlags[resTag]) else begin
				$display("CHECK FAILED %s: tag %0d expected %h flags %b actual %h flags %b",
					testName, resTag, expVal[resTag], expFlags[resTag], resValue, resFlags);
				errors++;
			end
			if (pending[resTag]) begin
				pending[resTag] = 1'b0;
				outstanding--;
			end
		end
	end

	// hang guard over the whole run
	initial begin
		repeat (WAIT_LIMIT * 100) @(posedge clk);
		$display("ERROR: simulation ran past its cycle limit");
		$display("** FAIL **");
		$finish;
	end

	// =================================================
	// stimulus
	// =================================================

	initial begin
		int base;
		int n;
		reqValid <= 1'b0;
		reqA <= '0;
		reqB <= '0;
		reqTag <= '0;
		resCredit <= 1'b0;
		nextTag = '0;
		for (int i = 0; i < 16; i++) pending[i] = 1'b0;
		n = 0;
		while (!rstN && n < WAIT_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (!rstN) begin
			$display("ERROR: reset was never released");
			errors++;
		end
		repeat (2) tick();

		startTest("exact");
		for (int i = 0; i < 16; i++) sendExact(1'b1);
		finishTest();

		// 1/3, 2/3 and a sign mix
		startTest("truncate");
		sendReq(32'h3F80_0000, 32'h4040_0000, 32'h3EAA_AAAA, NO_FLAGS, 1'b1);
		sendReq(32'h4000_0000, 32'h4040_0000, 32'h3F2A_AAAA, NO_FLAGS, 1'b1);
		sendReq(32'hC0C0_0000, 32'h4000_0000, 32'hC040_0000, NO_FLAGS, 1'b1);
		finishTest();

		startTest("special");
		sendReq(32'h40A0_0000, 32'h0000_0000, 32'h7F80_0000, DBZ, 1'b1);
		sendReq(32'h0000_0000, 32'h0000_0000, CANONICAL_NAN, INV, 1'b1);
		sendReq(32'h7F80_0000, 32'h7F80_0000, CANONICAL_NAN, INV, 1'b1);
		sendReq(32'h7FC0_1234, 32'h4000_0000, CANONICAL_NAN, INV, 1'b1);
		sendReq(32'h4040_0000, 32'hFF80_0001, CANONICAL_NAN, INV, 1'b1);
		sendReq(32'h0000_0000, 32'h40E0_0000, 32'h0000_0000, NO_FLAGS, 1'b1);
		sendReq(32'h0000_0000, 32'hC0E0_0000, 32'h8000_0000, NO_FLAGS, 1'b1);
		sendReq(32'h40E0_0000, 32'h7F80_0000, 32'h0000_0000, NO_FLAGS, 1'b1);
		finishTest();

		// largest normal over 0.5, smallest normal over 4
		startTest("range");
		sendReq(32'h7F7F_FFFF, 32'h3F00_0000, 32'h7F80_0000, OVUF, 1'b1);
		sendReq(32'h0080_0000, 32'h4080_0000, 32'h0000_0000, OVUF, 1'b1);
		finishTest();

		startTest("reqCredits");
		for (int i = 0; i < NUM_LANES; i++) sendExact(1'b1);
		assert (hostCredits() == 0) else begin
			$display("CHECK FAILED %s: host credits expected 0 actual %0d",
				testName, hostCredits());
			errors++;
		end
		// these stall until credits come back
		for (int i = 0; i < NUM_LANES; i++) sendExact(1'b1);
		finishTest();

		startTest("backpressure");
		base = received;
		sendReq(32'h4110_0000, 32'h4040_0000, 32'h4040_0000, NO_FLAGS, 1'b0);
		sendReq(32'h4120_0000, 32'h4080_0000, 32'h4020_0000, NO_FLAGS, 1'b0);
		// well past the 11-cycle lane latency
		repeat (24) tick();
		assert (received == base) else begin
			$display("CHECK FAILED %s: results without credit expected 0 actual %0d",
				testName, received - base);
			errors++;
		end
		assert (hostCredits() == 0) else begin
			$display("CHECK FAILED %s: host credits expected 0 actual %0d",
				testName, hostCredits());
			errors++;
		end
		for (int k = 1; k <= 2; k++) begin
			grantCredit();
			waitResults(base + k);
			repeat (6) tick();
			assert (received == base + k) else begin
				$display("CHECK FAILED %s: results after credit %0d expected %0d actual %0d",
					testName, k, k, received - base);
				errors++;
			end
		end
		finishTest();

		assert (uut.uSva.failCount == 0) else begin
			$display("ERROR: %0d protocol assertion failures", uut.uSva.failCount);
			errors++;
		end
		$display("tests %0d, results %0d, errors %0d", tests, received, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== bench/fdivTb_sva.sv ====
// concurrent protocol checks for the divide unit
// requests only reach a free lane, output credit rule, lane hold until grant
// bound into fdivTop

module fdivTb_sva #(
	parameter int NUM_LANES = 2
) (
	input logic clk,
	input logic rstN,
	input logic reqValid,
	input logic [NUM_LANES-1:0] busyVec,
	input logic haveCredit,
	input logic resValid,
	laneResultIf laneIf [NUM_LANES]
);

	timeunit 1ns;
	timeprecision 100ps;

	// count of failed protocol assertions
	int failCount;

	// a request arrives only while some lane is idle
	// so the lanes out of IDLE never outnumber the lanes that exist
	laneBound: assert property (@(posedge clk) disable iff (!rstN)
		reqValid |-> $countones(busyVec) < NUM_LANES)
	else begin
		$error("request arrived while every lane was out of IDLE");
		failCount++;
	end

	// a result pulse needs a credit in the grant cycle before it
	creditRule: assert property (@(posedge clk) disable iff (!rstN)
		resValid |-> $past(haveCredit))
	else begin
		$error("result left the unit without an output credit");
		failCount++;
	end

	// =================================================
	// lane channel hold
	// =================================================

	for (genvar i = 0; i < NUM_LANES; i++) begin : gLane
		// ungranted result stays up and unchanged
		holdUntilGrant: assert property (@(posedge clk) disable iff (!rstN)
			laneIf[i].valid && !laneIf[i].grant |=> laneIf[i].valid && $stable(laneIf[i].res))
		else begin
			$error("lane %0d dropped or changed its result before the grant", i);
			failCount++;
		end
	end

endmodule

bind fdivTop fdivTb_sva #(
	.NUM_LANES(NUM_LANES)
) uSva (
	.clk(clk),
	.rstN(rstN),
	.reqValid(reqValid),
	.busyVec(busyVec),
	.haveCredit(haveCredit),
	.resValid(resValid),
	.laneIf(laneIf)
);

// ==== compile.f ====
design/fdivPkg.sv
design/laneResultIf.sv
design/mantDivR8.sv
design/fdivLane.sv
design/resultArbiter.sv
design/fdivTop.sv
bench/clockGen.sv
bench/fdivTb_sva.sv
bench/fdivTb.sv

// ==== design/fdivLane.sv ====
// one divide lane
// operand unpack and special-case resolution
// exponent path, radix-8 mantissa divide, normalize, overflow/underflow flush
// result held on the lane channel until granted

module fdivLane (
	input logic clk,
	input logic rstN,
	input logic start,
	input fdivPkg::float32T opA,
	input fdivPkg::float32T opB,
	input fdivPkg::tagT tag,
	laneResultIf.lane out,
	output logic busy
);

	import fdivPkg::*;

	localparam int WID = $bits(mantT);
	localparam int BIAS = 127;

	laneStateT state;

	// unpacked fields, zero exponent counts as zero (no subnormals)
	logic signQ;
	logic zeroA, zeroB, infA, infB, nanA, nanB;
	// special case outcome decided at dispatch
	logic special;
	float32T specVal;
	flagsT specFlags;

	// captured at dispatch
	logic specialQ;
	float32T specValQ;
	flagsT specFlagsQ;
	logic signedQ;
	tagT tagQ;
	// biased quotient exponent, wide and signed to see both limits
	logic signed [9:0] expQ;

	// divider
	logic divLoad;
	logic [WID+2:0] quot;
	logic sticky;
	logic divDone;

	// pack stage
	logic signed [9:0] normExp;
	mantT normMant;
	logic nonZero;
	float32T packVal;
	flagsT packFlags;

	// ==================================================
	// unpack and special cases
	// ==================================================

	assign signQ = opA[31] ^ opB[31];
	assign zeroA = (opA[30:23] == 8'h00);
	assign zeroB = (opB[30:23] == 8'h00);
	assign infA = (opA[30:23] == 8'hFF) && (opA[22:0] == '0);
	assign infB = (opB[30:23] == 8'hFF) && (opB[22:0] == '0);
	assign nanA = (opA[30:23] == 8'hFF) && (opA[22:0] != '0);
	assign nanB = (opB[30:23] == 8'hFF) && (opB[22:0] != '0);

	always_comb begin
		special = 1'b1;
		specVal = '0;
		specFlags = '0;
		if (nanA || nanB || (infA && infB) || (zeroA && zeroB)) begin
			// invalid operation
			specVal = CANONICAL_NAN;
			specFlags[FLAG_INV] = 1'b1;
		end else if (infA) begin
			// inf over anything finite stays inf
			specVal = {signQ, 8'hFF, 23'h0};
		end else if (zeroB) begin
			// finite over zero
			specVal = {signQ, 8'hFF, 23'h0};
			specFlags[FLAG_DBZ] = 1'b1;
		end else if (zeroA || infB) begin
			specVal = {signQ, 31'h0};
		end else begin
			special = 1'b0;
		end
	end

	// divider runs only for two normal operands
	assign divLoad = start && (state == IDLE) && !special;

	mantDivR8 #(
		.WID(WID)
	) uDiv (
		.clk(clk),
		.rstN(rstN),
		.load(divLoad),
		.dividend({1'b1, opA[22:0]}),
		.divisor({1'b1, opB[22:0]}),
		.quotient(quot),
		.sticky(sticky),
		.done(divDone)
	);

	// operand side capture, payload only
	always_ff @(posedge clk) begin
		if (start && (state == IDLE)) begin
			specialQ <= special;
			specValQ <= specVal;
			specFlagsQ <= specFlags;
			signedQ <= signQ;
			tagQ <= tag;
			expQ <= $signed({2'b00, opA[30:23]}) - $signed({2'b00, opB[30:23]})
				+ 10'(BIAS);
		end
	end

	// ==================================================
	// normalize, truncate, flush
	// ==================================================

	always_comb begin
		// quotient in [0.5, 2), one-bit left shift when the integer bit is clear
		normExp = quot[WID+2] ? expQ : expQ - 10'sd1;
		normMant = quot[WID+2] ? quot[WID+2:3] : quot[WID+1:2];
		nonZero = (|quot) || sticky;
		packFlags = '0;
		packVal = {signedQ, normExp[7:0], normMant[WID-2:0]};
		if (specialQ) begin
			packVal = specValQ;
			packFlags = specFlagsQ;
		end else if (normExp >= 10'sd255) begin
			packVal = {signedQ, 8'hFF, 23'h0};
			packFlags[FLAG_OVUF] = 1'b1;
		end else if (normExp <= 10'sd0) begin
			// too small for a normal, flush to signed zero
			packVal = {signedQ, 31'h0};
			packFlags[FLAG_OVUF] = nonZero;
		end
	end

	// result register feeds the channel straight from PACK
	always_ff @(posedge clk) begin
		if (state == PACK) begin
			out.res <= '{value: packVal, flags: packFlags, tag: tagQ};
		end
	end

	// ==================================================
	// lane FSM
	// ==================================================

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= IDLE;
		end else begin
			unique case (state)
				IDLE: if (start) state <= special ? PACK : DIVIDE;
				DIVIDE: if (divDone) state <= PACK;
				PACK: state <= HOLD;
				HOLD: if (out.grant) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	assign out.valid = (state == HOLD);
	assign busy = (state != IDLE);

endmodule

// ==== design/fdivPkg.sv ====
// shared definitions for the single-precision divide unit
// float field widths, lane result record, flag positions
// lane state encoding and the quiet NaN the lanes emit

package fdivPkg;

	// ==================================================
	// field types
	// ==================================================

	// one ieee single-precision word
	typedef logic [31:0] float32T;
	// biased exponent
	typedef logic [7:0] expT;
	// mantissa with the hidden bit in front
	typedef logic [23:0] mantT;
	// host request id, echoed back with the result
	typedef logic [3:0] tagT;
	// exception flags, see bit positions below
	typedef logic [2:0] flagsT;

	// flag bit positions inside flagsT
	localparam int FLAG_DBZ = 0;
	localparam int FLAG_INV = 1;
	localparam int FLAG_OVUF = 2;

	// ==================================================
	// lane result and lane state
	// ==================================================

	// what one lane hands to the arbiter
	typedef struct packed {
		float32T value;
		flagsT flags;
		tagT tag;
	} laneResT;

	// lane sequencing
	typedef enum logic [1:0] {
		IDLE,
		DIVIDE,
		PACK,
		HOLD
	} laneStateT;

	// quiet NaN, positive sign, msb of the fraction set
	localparam float32T CANONICAL_NAN = 32'h7FC0_0000;

endpackage

// ==== design/fdivTop.sv ====
// floating-point divide unit top level
// request steering to the lowest idle lane
// request credit return, saturating output credit counter
// lane, channel and arbiter instances

module fdivTop #(
	parameter int NUM_LANES = 2,
	parameter int OUT_CREDITS = 4
) (
	input logic clk,
	input logic rstN,
	input logic reqValid,
	input fdivPkg::float32T reqA,
	input fdivPkg::float32T reqB,
	input fdivPkg::tagT reqTag,
	output logic reqCredit,
	input logic resCredit,
	output logic resValid,
	output fdivPkg::float32T resValue,
	output fdivPkg::flagsT resFlags,
	output fdivPkg::tagT resTag
);

	import fdivPkg::*;

	localparam int CW = $clog2(OUT_CREDITS + 1);

	logic [NUM_LANES-1:0] busyVec;
	logic [NUM_LANES-1:0] startVec;
	// banked output credits, never above OUT_CREDITS
	logic [CW-1:0] outCredits;
	logic haveCredit;
	logic creditUsed;
	logic anyGrant;
	laneResT arbRes;

	laneResultIf laneIf [NUM_LANES] ();

	// ==================================================
	// dispatch
	// ==================================================

	// one-hot start to the lowest lane not busy
	// host credits guarantee one is free whenever reqValid is high
	always_comb begin
		logic taken;
		taken = 1'b0;
		startVec = '0;
		for (int i = 0; i < NUM_LANES; i++) begin
			if (reqValid && !taken && !busyVec[i]) begin
				startVec[i] = 1'b1;
				taken = 1'b1;
			end
		end
	end

	for (genvar i = 0; i < NUM_LANES; i++) begin : gLane
		fdivLane uLane (
			.clk(clk),
			.rstN(rstN),
			.start(startVec[i]),
			.opA(reqA),
			.opB(reqB),
			.tag(reqTag),
			.out(laneIf[i]),
			.busy(busyVec[i])
		);
	end

	resultArbiter #(
		.NUM_LANES(NUM_LANES)
	) uArb (
		.clk(clk),
		.rstN(rstN),
		.haveCredit(haveCredit),
		.lanes(laneIf),
		.resValid(resValid),
		.res(arbRes),
		.creditUsed(creditUsed),
		.anyGrant(anyGrant)
	);

	// ==================================================
	// credits
	// ==================================================

	assign haveCredit = (outCredits != '0);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			outCredits <= '0;
			reqCredit <= 1'b0;
		end else begin
			// a granted lane frees up, give the host its credit back
			reqCredit <= anyGrant;
			if (resCredit && !creditUsed) begin
				if (outCredits != CW'(OUT_CREDITS)) outCredits <= outCredits + 1'b1;
			end else if (!resCredit && creditUsed) begin
				outCredits <= outCredits - 1'b1;
			end
		end
	end

	// result bus fields
	assign resValue = arbRes.value;
	assign resFlags = arbRes.flags;
	assign resTag = arbRes.tag;

endmodule

// ==== design/laneResultIf.sv ====
// lane to arbiter result channel
// valid/res from the lane, grant back from the arbiter

interface laneResultIf;

	import fdivPkg::*;

	// lane has a finished result waiting
	logic valid;
	// the result itself, held stable while valid
	laneResT res;
	// arbiter takes the result in this cycle
	logic grant;

	// producing side
	modport lane (
		output valid,
		output res,
		input grant
	);

	// consuming side
	modport arbiter (
		input valid,
		input res,
		output grant
	);

endinterface

// ==== design/mantDivR8.sv ====
// iterative radix-8 restoring mantissa divider
// three compare/subtract steps per cycle, counter msb is done
// quotient carries an integer bit plus WID+2 fraction bits

module mantDivR8 #(
	parameter int WID = 24
) (
	input logic clk,
	input logic rstN,
	input logic load,
	input logic [WID-1:0] dividend,
	input logic [WID-1:0] divisor,
	output logic [WID+2:0] quotient,
	output logic sticky,
	output logic done
);

	// three bits per pass
	localparam int ITER = (WID + 3) / 3;
	// one spare bit on top so the wrap below zero sets done
	localparam int CW = $clog2(ITER) + 1;

	logic [CW-1:0] cnt;
	// partial remainder, always below twice the divisor
	logic [WID:0] rem;
	// divisor latched at load, zero extended to the remainder width
	logic [WID:0] dvs;
	// {quotient bit, next shifted remainder} of each chained step
	logic [WID+1:0] step0;
	logic [WID+1:0] step1;
	logic [WID+1:0] step2;

	// one restoring step
	// subtract when it fits, then shift left for the next bit
	function automatic logic [WID+1:0] divStep(
		input logic [WID:0] r,
		input logic [WID:0] d
	);
		logic fits;
		logic [WID:0] t;
		fits = (r >= d);
		t = fits ? r - d : r;
		// t is below d here, so its msb is zero and the shift loses nothing
		return {fits, t[WID-1:0], 1'b0};
	endfunction

	// ==================================================
	// datapath
	// ==================================================

	// three steps chained inside one cycle
	assign step0 = divStep(rem, dvs);
	assign step1 = divStep(step0[WID:0], dvs);
	assign step2 = divStep(step1[WID:0], dvs);

	always_ff @(posedge clk) begin
		if (load) begin
			rem <= {1'b0, dividend};
			dvs <= {1'b0, divisor};
			quotient <= '0;
		end else if (!done) begin
			rem <= step2[WID:0];
			// first bit out is the most significant of the three
			quotient <= {quotient[WID-1:0], step0[WID+1], step1[WID+1], step2[WID+1]};
		end
	end

	// ==================================================
	// iteration counter
	// ==================================================

	// load ITER-1 so that ITER decrements pass before the msb flips
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			cnt <= '1;
		end else if (load) begin
			cnt <= CW'(ITER - 1);
		end else if (!done) begin
			cnt <= cnt - 1'b1;
		end
	end

	assign done = cnt[CW-1];

	// leftover remainder, non-zero means the quotient was cut short
	assign sticky = |rem;

endmodule

// ==== design/resultArbiter.sv ====
// round-robin arbiter from the lane channels onto the result bus
// grants only while the unit holds an output credit
// winner registered onto the bus, one pulse per grant

module resultArbiter #(
	parameter int NUM_LANES = 2
) (
	input logic clk,
	input logic rstN,
	input logic haveCredit,
	laneResultIf.arbiter lanes [NUM_LANES],
	output logic resValid,
	output fdivPkg::laneResT res,
	output logic creditUsed,
	output logic anyGrant
);

	import fdivPkg::*;

	localparam int IW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

	logic [NUM_LANES-1:0] validVec;
	logic [NUM_LANES-1:0] grantVec;
	laneResT resArr [NUM_LANES];
	// last lane that won, search starts just after it
	logic [IW-1:0] lastWin;
	logic [IW-1:0] winner;

	// flatten the interface array for indexing
	for (genvar i = 0; i < NUM_LANES; i++) begin : gLink
		assign validVec[i] = lanes[i].valid;
		assign resArr[i] = lanes[i].res;
		assign lanes[i].grant = grantVec[i];
	end

	// ==================================================
	// grant selection
	// ==================================================

	always_comb begin
		int unsigned idx;
		logic found;
		found = 1'b0;
		grantVec = '0;
		winner = lastWin;
		// walk once around the ring starting after lastWin
		for (int k = 1; k <= NUM_LANES; k++) begin
			idx = (int'(lastWin) + k) % NUM_LANES;
			if (haveCredit && !found && validVec[idx]) begin
				found = 1'b1;
				grantVec[idx] = 1'b1;
				winner = IW'(idx);
			end
		end
	end

	assign anyGrant = |grantVec;
	// a grant spends exactly one output credit
	assign creditUsed = |grantVec;

	// ==================================================
	// output register and priority pointer
	// ==================================================

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			resValid <= 1'b0;
			// lane 0 gets first look after reset
			lastWin <= IW'(NUM_LANES - 1);
		end else begin
			resValid <= anyGrant;
			if (anyGrant) lastWin <= winner;
		end
	end

	always_ff @(posedge clk) begin
		if (anyGrant) res <= resArr[winner];
	end

endmodule
